// File: hdl/dwnld_pkg.sv
/* Shared types and constants for the ROM download block:
   menu indices, serializer states, DDR burst geometry */
package dwnld_pkg;

    // Menu index carried by each host file
    typedef enum logic [7:0] {
        IDX_ROM   = 8'h00,  // ROM image, direct or through DDR
        IDX_MOD   = 8'h01,  // Core mode byte
        IDX_NVRAM = 8'h02,
        IDX_CHEAT = 8'h10,
        IDX_DIPSW = 8'd254  // Four DIP switch bytes
    } dwnld_idx_e;

    // Per-byte serializer sequence
    typedef enum logic [1:0] {
        SER_LOAD  = 2'd0,   // Buffer address settles, RAM read
        SER_SETUP = 2'd1,   // Word capture on byte 0
        SER_WRITE = 2'd2,   // Strobe to core
        SER_WAIT  = 2'd3    // prog_rdy or timeout
    } ser_state_e;

    // Burst geometry
    localparam int BURST_BITS = 7;                          // log2 words per burst
    localparam logic [7:0] BURST_WORDS = 8'd128;            // ddram_burstcnt value
    localparam int PAGE_BITS = 29 - 4 - BURST_BITS;         // DDR page counter width

    // Upper nibble of DDR word address, 0x3000_0000 byte region
    localparam logic [3:0] DDR_REGION = 4'd3;

    localparam int ADDR_BITS = 27;                          // ioctl and hps addresses

    // Cycles spent in SER_WAIT before giving up on prog_rdy
    localparam logic [5:0] WAIT_LIMIT = 6'd63;

    localparam logic [6:0] CORE_MOD_RESET = 7'd1;

endpackage

// File: hdl/dwnld_ctrl.sv
/* Index decode, core mode and DIP registers, download start and stop
   detection, ioctl output selection between host and serializer */
module dwnld_ctrl (
    input  logic                           rst,
    input  logic                           clk,
    input  logic                           hps_download,
    input  logic [7:0]                     hps_index,
    input  logic                           hps_wr,
    input  logic [dwnld_pkg::ADDR_BITS-1:0] hps_addr,
    input  logic [7:0]                     hps_dout,
    input  logic                           dwnld_busy,
    input  logic                           ser_we,
    input  logic [dwnld_pkg::ADDR_BITS-1:0] ser_addr,
    input  logic [7:0]                     ser_data,
    output logic                           downloading,
    output logic                           hps_wait,
    output logic                           ddr_active,
    output logic [dwnld_pkg::ADDR_BITS-1:0] ddr_len,
    output logic                           ioctl_rom_wr,
    output logic                           ioctl_ram,
    output logic                           ioctl_cheat,
    output logic [dwnld_pkg::ADDR_BITS-1:0] ioctl_addr,
    output logic [7:0]                     ioctl_dout,
    output logic [6:0]                     core_mod,
    output logic [31:0]                    dipsw
);
    import dwnld_pkg::*;

    logic            last_dwn;      // hps_download one cycle ago
    logic            last_busy;     // dwnld_busy one cycle ago
    logic            wr_latch;      // ROM byte seen in this file
    logic            ddr_dwn;       // DDR path running
    logic [3:0][7:0] dsw;           // DIP bytes, byte 0 lowest

    logic dwn_rise;
    logic dwn_fall;
    logic busy_fall;
    logic ddr_end;

    assign dwn_rise  = hps_download && !last_dwn;
    assign dwn_fall  = !hps_download && last_dwn;
    assign busy_fall = last_busy && !dwnld_busy;
    assign ddr_end   = ddr_dwn && (ser_addr == ddr_len);   // All bytes sent

    assign hps_wait   = ddr_dwn;
    assign ddr_active = ddr_dwn;
    assign dipsw      = dsw;

    // Host bytes pass straight through unless DDR path owns the bus
    always_comb begin
        if (ddr_dwn) begin
            ioctl_rom_wr = ser_we;
            ioctl_addr   = ser_addr;
            ioctl_dout   = ser_data;
        end else begin
            ioctl_rom_wr = hps_wr && (hps_index == IDX_ROM || hps_index == IDX_NVRAM);
            ioctl_addr   = hps_addr;
            ioctl_dout   = hps_dout;
        end
    end

    // Index flags, one cycle behind
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ioctl_ram   <= 1'b0;
            ioctl_cheat <= 1'b0;
        end else begin
            ioctl_ram   <= hps_download && (hps_index == IDX_NVRAM);
            ioctl_cheat <= hps_download && (hps_index == IDX_CHEAT);
        end
    end

    // Configuration registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            core_mod <= CORE_MOD_RESET;
            dsw      <= '1;                 // All switches off
        end else if (hps_wr) begin
            // Odd address is the duplicate write of a 16-bit host transfer
            if (hps_index == IDX_MOD && !hps_addr[0])
                core_mod <= hps_dout[6:0];
            if (hps_index == IDX_DIPSW && hps_addr[ADDR_BITS-1:2] == '0)
                dsw[hps_addr[1:0]] <= hps_dout;
        end
    end

    // Download start and stop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_dwn    <= 1'b0;
            last_busy   <= 1'b0;
            wr_latch    <= 1'b0;
            ddr_dwn     <= 1'b0;
            downloading <= 1'b0;
            ddr_len     <= '0;
        end else begin
            last_dwn  <= hps_download;
            last_busy <= dwnld_busy;
            if (dwn_rise && hps_index == IDX_ROM) begin
                downloading <= 1'b1;
                wr_latch    <= 1'b0;
            end else if (hps_wr && hps_index == IDX_ROM) begin
                wr_latch <= 1'b1;
            end
            if (dwn_fall && downloading) begin
                if (wr_latch) begin
                    downloading <= 1'b0;    // Plain host download done
                end else begin
                    // Empty file, length given by final address
                    ddr_len <= hps_addr;
                    ddr_dwn <= 1'b1;
                end
            end
            if (busy_fall || ddr_end) begin
                downloading <= 1'b0;
                ddr_dwn     <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/ddr_page_reader.sv
/* DDR burst reader: one request per page, beat counting into the
   burst buffer, page pointer advance */
module ddr_page_reader (
    input  logic                             rst,
    input  logic                             clk,
    input  logic                             ddr_active,
    input  logic                             tx_done,
    input  logic                             ddram_busy,
    input  logic [63:0]                      ddram_dout,
    input  logic                             ddram_dout_ready,
    output logic                             ddram_rd,
    output logic [7:0]                       ddram_burstcnt,
    output logic [28:0]                      ddram_addr,
    output logic                             buf_we,
    output logic [dwnld_pkg::BURST_BITS-1:0] buf_waddr,
    output logic [63:0]                      buf_wdata,
    output logic                             page_ready
);
    import dwnld_pkg::*;

    logic                  rd_pend;     // Request waiting for busy low
    logic                  beat_wait;   // Burst in flight
    logic [BURST_BITS-1:0] beat_cnt;
    logic [PAGE_BITS-1:0]  page;
    logic                  beat_ok;

    assign beat_ok = beat_wait && ddram_dout_ready && !ddram_busy;

    // Request only leaves when DDR can take it
    assign ddram_rd       = rd_pend && ddr_active && !ddram_busy;
    assign ddram_burstcnt = BURST_WORDS;
    assign ddram_addr     = {DDR_REGION, page, {BURST_BITS{1'b0}}};

    assign buf_we    = beat_ok;
    assign buf_waddr = beat_cnt;
    assign buf_wdata = ddram_dout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend    <= 1'b0;
            beat_wait  <= 1'b0;
            beat_cnt   <= '0;
            page       <= '0;
            page_ready <= 1'b0;
        end else if (!ddr_active) begin
            // Idle, next download starts at page 0
            rd_pend    <= 1'b0;
            beat_wait  <= 1'b0;
            beat_cnt   <= '0;
            page       <= '0;
            page_ready <= 1'b0;
        end else begin
            page_ready <= 1'b0;                     // Single-cycle pulse
            if (!ddram_busy) begin
                if (rd_pend)
                    rd_pend <= 1'b0;                // Accepted this cycle
                if (!beat_wait) begin
                    beat_cnt <= '0;
                    // Serializer idle and no page just handed over
                    if (tx_done && !page_ready) begin
                        rd_pend   <= 1'b1;
                        beat_wait <= 1'b1;
                    end
                end else if (ddram_dout_ready) begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (&beat_cnt) begin            // Last beat of burst
                        beat_wait  <= 1'b0;
                        page_ready <= 1'b1;
                        page       <= page + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/burst_buffer.sv
/* Single-burst 64-bit RAM, one write port and one registered read port */
module burst_buffer (
    input  logic                             clk,
    input  logic                             we,
    input  logic [dwnld_pkg::BURST_BITS-1:0] waddr,
    input  logic [63:0]                      wdata,
    input  logic [dwnld_pkg::BURST_BITS-1:0] raddr,
    output logic [63:0]                      q
);
    import dwnld_pkg::*;

    logic [63:0] mem [BURST_WORDS];     // One DDR burst

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // Registered read, data one cycle after raddr
    always_ff @(posedge clk) begin
        q <= mem[raddr];
    end

endmodule

// File: hdl/byte_serializer.sv
/* Byte serializer: buffered 64-bit words out as paced byte writes,
   prog_rdy handshake with timeout, running byte address */
module byte_serializer (
    input  logic                              rst,
    input  logic                              clk,
    input  logic                              ddr_active,
    input  logic                              page_ready,
    input  logic                              prog_rdy,
    input  logic [63:0]                       buf_q,
    output logic [dwnld_pkg::BURST_BITS-1:0]  buf_raddr,
    output logic                              tx_done,
    output logic                              ser_we,
    output logic [dwnld_pkg::ADDR_BITS-1:0]   ser_addr,
    output logic [7:0]                        ser_data
);
    import dwnld_pkg::*;

    ser_state_e  state;
    logic [5:0]  wait_cnt;          // Cycles spent in SER_WAIT
    logic [63:0] shreg;             // Current word, low byte goes next
    logic        running;
    logic        step;              // Byte accepted or timed out

    assign running   = ddr_active && !tx_done;
    assign step      = running && state == SER_WAIT &&
                       (prog_rdy || wait_cnt == WAIT_LIMIT - 6'd1);
    assign buf_raddr = ser_addr[BURST_BITS+2:3];   // Word within the page
    assign ser_we    = running && state == SER_WRITE;
    assign ser_data  = shreg[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SER_LOAD;
            wait_cnt <= '0;
            tx_done  <= 1'b1;
            ser_addr <= '0;
        end else if (!ddr_active) begin
            // Drop any partial page
            state    <= SER_LOAD;
            wait_cnt <= '0;
            tx_done  <= 1'b1;
            ser_addr <= '0;
        end else if (page_ready) begin
            tx_done  <= 1'b0;           // New page in buffer
            state    <= SER_LOAD;
            wait_cnt <= '0;
        end else if (!tx_done) begin
            case (state)
                SER_LOAD:  state <= SER_SETUP;
                SER_SETUP: state <= SER_WRITE;
                SER_WRITE: begin
                    state    <= SER_WAIT;
                    wait_cnt <= '0;
                end
                SER_WAIT: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (step) begin
                        state    <= SER_LOAD;
                        ser_addr <= ser_addr + 1'b1;
                        if (&ser_addr[BURST_BITS+2:0])
                            tx_done <= 1'b1;    // Last byte of page
                    end
                end
                default: state <= SER_LOAD;
            endcase
        end
    end

    // Word register, loaded on byte 0 and shifted after each byte
    always_ff @(posedge clk) begin
        if (running && state == SER_SETUP && ser_addr[2:0] == 3'd0)
            shreg <= buf_q;
        else if (step)
            shreg <= {8'd0, shreg[63:8]};
    end

endmodule

// File: hdl/dwnld_top.sv
/* ROM download top level: control, DDR reader, burst buffer, serializer */
module dwnld_top (
    input  logic                            rst,
    input  logic                            clk,
    // Host
    input  logic                            hps_download,
    input  logic [7:0]                      hps_index,
    input  logic                            hps_wr,
    input  logic [dwnld_pkg::ADDR_BITS-1:0] hps_addr,
    input  logic [7:0]                      hps_dout,
    output logic                            hps_wait,
    // Core
    output logic                            downloading,
    input  logic                            dwnld_busy,
    input  logic                            prog_rdy,
    output logic                            ioctl_rom_wr,
    output logic                            ioctl_ram,
    output logic                            ioctl_cheat,
    output logic [dwnld_pkg::ADDR_BITS-1:0] ioctl_addr,
    output logic [7:0]                      ioctl_dout,
    output logic [6:0]                      core_mod,
    output logic [31:0]                     dipsw,
    // DDR
    input  logic                            ddram_busy,
    output logic [7:0]                      ddram_burstcnt,
    output logic [28:0]                     ddram_addr,
    input  logic [63:0]                     ddram_dout,
    input  logic                            ddram_dout_ready,
    output logic                            ddram_rd
);
    import dwnld_pkg::*;

    logic                  ddr_active;
    logic                  tx_done;
    logic                  page_ready;
    logic                  buf_we;
    logic [BURST_BITS-1:0] buf_waddr;
    logic [BURST_BITS-1:0] buf_raddr;
    logic [63:0]           buf_wdata;
    logic [63:0]           buf_q;
    logic                  ser_we;
    logic [ADDR_BITS-1:0]  ser_addr;
    logic [7:0]            ser_data;

    dwnld_ctrl u_ctrl (
        .rst          ( rst          ),
        .clk          ( clk          ),
        .hps_download ( hps_download ),
        .hps_index    ( hps_index    ),
        .hps_wr       ( hps_wr       ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .dwnld_busy   ( dwnld_busy   ),
        .ser_we       ( ser_we       ),
        .ser_addr     ( ser_addr     ),
        .ser_data     ( ser_data     ),
        .downloading  ( downloading  ),
        .hps_wait     ( hps_wait     ),
        .ddr_active   ( ddr_active   ),
        .ddr_len      (              ),  // Only compared inside control
        .ioctl_rom_wr ( ioctl_rom_wr ),
        .ioctl_ram    ( ioctl_ram    ),
        .ioctl_cheat  ( ioctl_cheat  ),
        .ioctl_addr   ( ioctl_addr   ),
        .ioctl_dout   ( ioctl_dout   ),
        .core_mod     ( core_mod     ),
        .dipsw        ( dipsw        )
    );

    ddr_page_reader u_reader (
        .rst              ( rst              ),
        .clk              ( clk              ),
        .ddr_active       ( ddr_active       ),
        .tx_done          ( tx_done          ),
        .ddram_busy       ( ddram_busy       ),
        .ddram_dout       ( ddram_dout       ),
        .ddram_dout_ready ( ddram_dout_ready ),
        .ddram_rd         ( ddram_rd         ),
        .ddram_burstcnt   ( ddram_burstcnt   ),
        .ddram_addr       ( ddram_addr       ),
        .buf_we           ( buf_we           ),
        .buf_waddr        ( buf_waddr        ),
        .buf_wdata        ( buf_wdata        ),
        .page_ready       ( page_ready       )
    );

    burst_buffer u_buffer (
        .clk   ( clk       ),
        .we    ( buf_we    ),
        .waddr ( buf_waddr ),
        .wdata ( buf_wdata ),
        .raddr ( buf_raddr ),
        .q     ( buf_q     )
    );

    byte_serializer u_ser (
        .rst        ( rst        ),
        .clk        ( clk        ),
        .ddr_active ( ddr_active ),
        .page_ready ( page_ready ),
        .prog_rdy   ( prog_rdy   ),
        .buf_q      ( buf_q      ),
        .buf_raddr  ( buf_raddr  ),
        .tx_done    ( tx_done    ),
        .ser_we     ( ser_we     ),
        .ser_addr   ( ser_addr   ),
        .ser_data   ( ser_data   )
    );

endmodule

// File: bench/ddr_model.sv
/* Behavioural DDR read port: busy from an external random bit,
   bursts of ddram_burstcnt beats with a data rule per word address */
module ddr_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        busy_req,       // Random busy request from the testbench
    input  logic        ddram_rd,
    input  logic [28:0] ddram_addr,
    input  logic [7:0]  ddram_burstcnt,
    output logic        ddram_busy,
    output logic [63:0] ddram_dout,
    output logic        ddram_dout_ready,
    output logic        streaming
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [28:0] word_addr;             // Address of the beat on ddram_dout
    logic [8:0]  beats_left;

    // Byte b of word wa is (wa*8 + b) xor 0x5a
    function automatic logic [63:0] word_data(input logic [28:0] wa);
        logic [63:0] d;
        logic [31:0] byte_addr;
        for (int b = 0; b < 8; b++) begin
            byte_addr = {wa, 3'b000} + 32'(b);
            d[8*b +: 8] = byte_addr[7:0] ^ 8'h5a;
        end
        return d;
    endfunction

    assign streaming = beats_left != 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ddram_busy       <= 1'b0;
            ddram_dout_ready <= 1'b0;
            ddram_dout       <= '0;
            word_addr        <= '0;
            beats_left       <= '0;
        end else begin
            ddram_busy <= busy_req;
            if (ddram_rd && !ddram_busy) begin      // Request accepted
                word_addr        <= ddram_addr;
                beats_left       <= {1'b0, ddram_burstcnt};
                ddram_dout       <= word_data(ddram_addr);
                ddram_dout_ready <= 1'b1;
            end else if (ddram_dout_ready && !ddram_busy) begin
                // Beat taken, present the next one
                beats_left <= beats_left - 9'd1;
                word_addr  <= word_addr + 29'd1;
                ddram_dout <= word_data(word_addr + 29'd1);
                if (beats_left == 9'd1)
                    ddram_dout_ready <= 1'b0;
            end
        end
    end

endmodule

// File: bench/dwnld_assertions.sv
/* Concurrent checks on the download top level: DDR request rules,
   single-cycle ROM strobes on the DDR path */
module dwnld_assertions (
    input logic        clk,
    input logic        rst,
    input logic        ddram_rd,
    input logic        ddram_busy,
    input logic        hps_wait,
    input logic        ioctl_rom_wr,
    input logic [28:0] ddram_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // Request only while DDR is free and the DDR path is active
    a_rd_legal: assert property (@(posedge clk) disable iff (rst)
        ddram_rd |-> (!ddram_busy && hps_wait))
        else $error("ddram_rd issued while busy or outside DDR download");

    a_rd_region: assert property (@(posedge clk) disable iff (rst)
        ddram_rd |-> (ddram_addr[28:25] == 4'd3))
        else $error("ddram_addr outside DDR region 3");

    a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
        (hps_wait && ioctl_rom_wr) |=> !ioctl_rom_wr)
        else $error("ioctl_rom_wr longer than one cycle during DDR download");

endmodule

bind dwnld_top dwnld_assertions u_assertions (.*);

// File: bench/dwnld_tb.sv
/* Testbench for dwnld_top: clock, reset, watchdog, LCG stimulus,
   write monitor and directed tests for host, config and DDR paths */
module dwnld_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dwnld_pkg::*;

    localparam int TOTAL_BYTES     = 2000 + 300 + 300 + 1500 + 32;
    localparam int MAX_BYTE_CYCLES = 72;    // 66 on timeout, plus burst share
    localparam int WATCHDOG_CYCLES = TOTAL_BYTES * MAX_BYTE_CYCLES + 5000;

    logic                 clk;
    logic                 rst;
    logic                 hps_download;
    logic [7:0]           hps_index;
    logic                 hps_wr;
    logic [ADDR_BITS-1:0] hps_addr;
    logic [7:0]           hps_dout;
    logic                 hps_wait;
    logic                 downloading;
    logic                 dwnld_busy;
    logic                 prog_rdy;
    logic                 ioctl_rom_wr;
    logic                 ioctl_ram;
    logic                 ioctl_cheat;
    logic [ADDR_BITS-1:0] ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic [6:0]           core_mod;
    logic [31:0]          dipsw;
    logic                 ddram_busy;
    logic [7:0]           ddram_burstcnt;
    logic [28:0]          ddram_addr;
    logic [63:0]          ddram_dout;
    logic                 ddram_dout_ready;
    logic                 ddram_rd;
    logic                 busy_req;
    logic                 model_streaming;

    logic [31:0] lcg_state = 32'ha11e03f1;
    int          prog_mode;                 // 0 ready, 1 random, 2 stuck low
    int          errors;
    int          checks;
    int          exp_addr;                  // Next DDR byte address expected
    int          wr_count;                  // All ROM strobes seen
    int          rd_count;                  // DDR requests seen

    dwnld_top u_dwnld_top (.*);

    ddr_model u_ddr_model (
        .clk              ( clk              ),
        .rst              ( rst              ),
        .busy_req         ( busy_req         ),
        .ddram_rd         ( ddram_rd         ),
        .ddram_addr       ( ddram_addr       ),
        .ddram_burstcnt   ( ddram_burstcnt   ),
        .ddram_busy       ( ddram_busy       ),
        .ddram_dout       ( ddram_dout       ),
        .ddram_dout_ready ( ddram_dout_ready ),
        .streaming        ( model_streaming  )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Model rule: word 0x0600_0000 + a/8, byte a%8, xor 0x5a
    function automatic logic [7:0] expected_byte(input int a);
        logic [31:0] word;
        logic [31:0] byte_addr;
        word = 32'h0600_0000 + 32'(a / 8);
        byte_addr = word * 8 + 32'(a % 8);
        return byte_addr[7:0] ^ 8'h5a;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("Failure: %s", what);
    endtask

    // Random DDR busy and core ready, one LCG stream
    always @(posedge clk) begin : random_drive
        logic [31:0] rnd;
        rnd = lcg_next();
        busy_req <= rnd[31:30] == 2'b00;    // Busy about a quarter of cycles
        case (prog_mode)
            0:       prog_rdy <= 1'b1;
            1:       prog_rdy <= rnd[17];
            default: prog_rdy <= 1'b0;
        endcase
    end

    // Write monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && ioctl_rom_wr) begin
            wr_count++;
            if (hps_wait) begin
                check("downloading", downloading, 1);
                check("ioctl_addr", ioctl_addr, exp_addr);
                check("ioctl_dout", ioctl_dout, expected_byte(exp_addr));
                exp_addr++;
            end
        end
        if (!rst && ddram_rd) begin
            rd_count++;
            check("ddram_burstcnt", ddram_burstcnt, 128);
        end
    end

    task automatic start_file(input logic [7:0] idx);
        @(posedge clk);
        hps_index    <= idx;
        hps_addr     <= '0;
        hps_download <= 1'b1;
    endtask

    task automatic end_file(input int last_addr);
        @(posedge clk);
        hps_addr     <= ADDR_BITS'(last_addr);
        hps_download <= 1'b0;
    endtask

    // One host byte, ROM strobe checked in the same cycle
    task automatic host_write(input int addr, input logic [7:0] data, input logic exp_rom);
        @(posedge clk);
        hps_wr   <= 1'b1;
        hps_addr <= ADDR_BITS'(addr);
        hps_dout <= data;
        @(negedge clk);
        check("ioctl_rom_wr", ioctl_rom_wr, exp_rom);
        if (exp_rom) begin
            check("ioctl_addr", ioctl_addr, addr);
            check("ioctl_dout", ioctl_dout, data);
        end
        @(posedge clk);
        hps_wr <= 1'b0;
    endtask

    task automatic reset_test();
        check("downloading", downloading, 0);
        check("hps_wait", hps_wait, 0);
        check("ddram_rd", ddram_rd, 0);
        check("ioctl_rom_wr", ioctl_rom_wr, 0);
        check("tx_done", u_dwnld_top.tx_done, 1);
        check("core_mod", core_mod, 1);
        check("dipsw", dipsw, 32'hffff_ffff);
    endtask

    task automatic host_test();
        start_file(IDX_ROM);
        @(negedge clk);
        check("downloading", downloading, 0);
        @(negedge clk);
        check("downloading", downloading, 1);   // One cycle after start
        for (int i = 0; i < 8; i++)
            host_write(i, 8'(i * 37 + 5), 1'b1);
        end_file(8);
        @(negedge clk);
        check("downloading", downloading, 1);
        @(negedge clk);
        check("downloading", downloading, 0);
        // NVRAM file
        start_file(IDX_NVRAM);
        @(negedge clk);
        check("ioctl_ram", ioctl_ram, 0);
        @(negedge clk);
        check("ioctl_ram", ioctl_ram, 1);
        for (int i = 0; i < 4; i++)
            host_write(i, 8'(8'hc0 + i), 1'b1);
        check("downloading", downloading, 0);
        end_file(4);
        repeat (2) @(negedge clk);
        check("ioctl_ram", ioctl_ram, 0);
        // Cheat file, no ROM strobe
        start_file(IDX_CHEAT);
        repeat (2) @(negedge clk);
        check("ioctl_cheat", ioctl_cheat, 1);
        host_write(0, 8'h99, 1'b0);
        end_file(1);
        repeat (2) @(negedge clk);
        check("ioctl_cheat", ioctl_cheat, 0);
    endtask

    task automatic config_test();
        start_file(IDX_MOD);
        host_write(0, 8'ha5, 1'b0);
        @(negedge clk);
        check("core_mod", core_mod, 7'h25);
        host_write(1, 8'h7f, 1'b0);             // Odd address ignored
        @(negedge clk);
        check("core_mod", core_mod, 7'h25);
        end_file(2);
        start_file(IDX_DIPSW);
        for (int i = 0; i < 4; i++)
            host_write(i, 8'(8'h11 * (i + 1)), 1'b0);
        @(negedge clk);
        check("dipsw", dipsw, 32'h4433_2211);
        end_file(4);
        repeat (2) @(posedge clk);
    endtask

    // Empty ROM file of length len, optional stop at byte stop_at
    task automatic ddr_download(input int len, input int stop_at);
        int n;
        int strobes;
        n = 0;
        while (model_streaming && n < 1000) begin
            @(posedge clk);
            n++;
        end
        exp_addr = 0;
        rd_count = 0;
        start_file(IDX_ROM);
        dwnld_busy <= stop_at >= 0;
        repeat (2) @(posedge clk);
        hps_addr     <= ADDR_BITS'(len);
        hps_download <= 1'b0;
        @(posedge clk);                         // Fall seen here
        @(negedge clk);
        check("hps_wait", hps_wait, 1);
        n = 0;
        while (hps_wait && n < len * MAX_BYTE_CYCLES + 2000) begin
            @(posedge clk);
            if (stop_at >= 0 && exp_addr >= stop_at)
                dwnld_busy <= 1'b0;
            n++;
        end
        @(negedge clk);
        if (hps_wait)
            report("DDR download did not end in time");
        check("downloading", downloading, 0);
        if (stop_at < 0) begin
            check("byte count", exp_addr, len);
            check("ddram_rd count", rd_count, (len + 1023) / 1024);
        end else begin
            strobes = wr_count;
            repeat (200) @(negedge clk);
            if (wr_count != strobes)
                report("ROM writes continued after early stop");
            if (exp_addr >= len)
                report("early stop came after the whole file");
        end
        @(posedge clk);
        dwnld_busy <= 1'b0;
    endtask

    task automatic ddr_test();
        ddr_download(2000, -1);
    endtask

    task automatic backpressure_test();
        prog_mode = 1;
        ddr_download(300, -1);
        prog_mode = 2;                          // Every byte by timeout
        ddr_download(300, -1);
        prog_mode = 0;
    endtask

    task automatic early_stop_test();
        ddr_download(2000, 1500);
    endtask

    initial begin
        rst          = 1'b1;
        hps_download = 1'b0;
        hps_index    = 8'h00;
        hps_wr       = 1'b0;
        hps_addr     = '0;
        hps_dout     = 8'h00;
        dwnld_busy   = 1'b0;
        prog_rdy     = 1'b1;
        busy_req     = 1'b0;
        prog_mode    = 0;
        errors       = 0;
        checks       = 0;
        exp_addr     = 0;
        wr_count     = 0;
        rd_count     = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_test();
        host_test();
        config_test();
        ddr_test();
        backpressure_test();
        early_stop_test();
        repeat (10) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Sized from all bytes at the slowest byte rate
    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: src.f
hdl/dwnld_pkg.sv
hdl/dwnld_ctrl.sv
hdl/ddr_page_reader.sv
hdl/burst_buffer.sv
hdl/byte_serializer.sv
hdl/dwnld_top.sv
bench/ddr_model.sv
bench/dwnld_assertions.sv
bench/dwnld_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the download testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module dwnld_tb -f src.f -o dwnld_sim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/dwnld_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Result comes from the log
if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
    exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" "$LOG"; then
    echo "No result line in $LOG"
    exit 1
fi
exit 0
